// ==== Bender.yml ====
package:
  name: corr_block

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/corr_pkg.sv
      - logic/corr_accumulator.sv
      - logic/vis_bank_ram.sv
      - logic/vis_readback.sv
      - logic/corr_block.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verification/corr_block_tb.sv

// ==== build.f ====
+incdir+logic
logic/corr_pkg.sv
logic/corr_accumulator.sv
logic/vis_bank_ram.sv
logic/vis_readback.sv
logic/corr_block.sv
verification/corr_block_tb.sv

// ==== logic/corr_accumulator.sv ====
`timescale 1ns/1ps
`include "corr_config.svh"

module corr_accumulator (
   input  logic                   sram_ck_i,
   input  logic                   reset_i,
   input  logic                   en_i,       // Sample valid
   input  logic                   sw_i,       // Bank switch, ends the frame
   input  corr_pkg::corr_sample_t sample_i,
   output logic                   vis_wr_o,   // Frame ready, one cycle
   output corr_pkg::vis_frame_t   frame_o
);

   // ----------------------------------------------------------
   // Pair table
   // ----------------------------------------------------------
   localparam int unsigned pair_a [`CORR_NLANE] =
      '{`CORR_PAIR_A0, `CORR_PAIR_A1, `CORR_PAIR_A2, `CORR_PAIR_A3};
   localparam int unsigned pair_b [`CORR_NLANE] =
      '{`CORR_PAIR_B0, `CORR_PAIR_B1, `CORR_PAIR_B2, `CORR_PAIR_B3};

   corr_pkg::acc_state_e  state_q;
   corr_pkg::vis_frame_t  acc_q;      // Running sums
   corr_pkg::vis_frame_t  base;       // Old sum or zero after a switch
   corr_pkg::vis_frame_t  sum_d;      // Sum including this cycle
   logic signed [2:0]     prod_re [`CORR_NLANE];
   logic signed [2:0]     prod_im [`CORR_NLANE];

   // Sign bit to +1/-1
   function automatic logic signed [2:0] sign_of(input logic neg);
      return neg ? -3'sd1 : 3'sd1;
   endfunction

   // ----------------------------------------------------------
   // Complex sign products, one per lane
   // ----------------------------------------------------------
   always_comb begin
      for (int l = 0; l < `CORR_NLANE; l++) begin
         logic ar, ai, br, bi;
         ar = sample_i.re[pair_a[l]];
         ai = sample_i.im[pair_a[l]];
         br = sample_i.re[pair_b[l]];
         bi = sample_i.im[pair_b[l]];
         // ar*br + ai*bi
         prod_re[l] = sign_of(ar ^ br) + sign_of(ai ^ bi);
         // ai*br - ar*bi
         prod_im[l] = sign_of(ai ^ br) - sign_of(ar ^ bi);
      end
   end

   // Clear state feeds a zero instead of the stale sum
   assign base = (state_q == corr_pkg::ACC_CLEAR) ? '0 : acc_q;

   always_comb begin
      for (int l = 0; l < `CORR_NLANE; l++) begin
         sum_d[l].re = $signed(base[l].re) + (en_i ? prod_re[l] : 3'sd0);
         sum_d[l].im = $signed(base[l].im) + (en_i ? prod_im[l] : 3'sd0);
      end
   end

   // ----------------------------------------------------------
   // Sums and frame capture
   // ----------------------------------------------------------
   always_ff @(posedge sram_ck_i) begin
      for (int l = 0; l < `CORR_NLANE; l++) begin
         if (en_i) begin
            acc_q[l] <= sum_d[l];  // Wraps modulo width
         end
      end
      if (sw_i) begin
         frame_o <= sum_d;         // Includes this cycle's sample
      end
   end

   // Control
   always_ff @(posedge sram_ck_i) begin
      if (reset_i) begin
         state_q  <= corr_pkg::ACC_CLEAR;
         vis_wr_o <= 1'b0;
      end else begin
         vis_wr_o <= sw_i;                    // Frame stable in t+1
         if (sw_i) begin
            state_q <= corr_pkg::ACC_CLEAR;   // Restart after switch
         end else if (en_i) begin
            state_q <= corr_pkg::ACC_RUN;
         end
      end
   end

   // ----------------------------------------------------------
   // Checks
   // ----------------------------------------------------------
   // Caller may not switch twice in a row, the buffer needs a gap
   sw_spacing_a : assert property (
      @(posedge sram_ck_i) disable iff (reset_i) sw_i |=> !sw_i
   ) else $error("sw_i high in consecutive cycles");

endmodule

// ==== logic/corr_block.sv ====
`timescale 1ns/1ps
`include "corr_config.svh"

module corr_block (
   input  logic                          sram_ck_i,
   input  logic                          reset_i,
   input  logic                          en_i,       // Sample valid
   input  logic                          sw_i,       // Bank switch
   input  logic                          sram_ce_i,  // Read enable
   input  corr_pkg::corr_sample_t        sample_i,
   input  corr_pkg::vis_addr_t           sram_ad_i,
   output logic signed [`CORR_ACCUM-1:0] sram_do_o   // Two cycles after ce
);

   // ----------------------------------------------------------
   // Interconnect
   // ----------------------------------------------------------
   logic                 vis_wr;    // Producer to buffer
   corr_pkg::vis_frame_t frame;
   logic                 rd_en;     // Consumer to buffer
   logic [1:0]           rd_lane;
   corr_pkg::vis_entry_t rd_entry;  // Buffer to consumer

   // Producer
   corr_accumulator corr_accumulator_i (
      .sram_ck_i (sram_ck_i),
      .reset_i   (reset_i),
      .en_i      (en_i),
      .sw_i      (sw_i),
      .sample_i  (sample_i),
      .vis_wr_o  (vis_wr),
      .frame_o   (frame)
   );

   // Buffer
   vis_bank_ram vis_bank_ram_i (
      .sram_ck_i  (sram_ck_i),
      .reset_i    (reset_i),
      .wr_i       (vis_wr),
      .frame_i    (frame),
      .rd_en_i    (rd_en),
      .rd_lane_i  (rd_lane),
      .rd_entry_o (rd_entry)
   );

   // Consumer
   vis_readback vis_readback_i (
      .sram_ck_i  (sram_ck_i),
      .reset_i    (reset_i),
      .sram_ce_i  (sram_ce_i),
      .sram_ad_i  (sram_ad_i),
      .rd_en_o    (rd_en),
      .rd_lane_o  (rd_lane),
      .rd_entry_i (rd_entry),
      .sram_do_o  (sram_do_o)
   );

endmodule

// ==== logic/corr_config.svh ====
`ifndef CORR_CONFIG_SVH
`define CORR_CONFIG_SVH

// ----------------------------------------------------------
// Array geometry
// ----------------------------------------------------------
`define CORR_NANT  8   // Antennas feeding the block
`define CORR_NLANE 4   // Correlated pairs, one lane each
`define CORR_ACCUM 16  // Accumulator width, wraps on overflow

// ----------------------------------------------------------
// Antenna pair table, lane n correlates A(n) with B(n)
// ----------------------------------------------------------
`define CORR_PAIR_A0 0
`define CORR_PAIR_B0 1
`define CORR_PAIR_A1 2
`define CORR_PAIR_B1 3
`define CORR_PAIR_A2 1
`define CORR_PAIR_B2 5
`define CORR_PAIR_A3 4
`define CORR_PAIR_B3 7

`endif

// ==== logic/corr_pkg.sv ====
`include "corr_config.svh"

package corr_pkg;

   // One-bit complex samples for every antenna
   // Bit set means -1, clear means +1
   typedef struct packed {
      logic [`CORR_NANT-1:0] re;  // Real sign bits
      logic [`CORR_NANT-1:0] im;  // Imaginary sign bits
   } corr_sample_t;

   // One complex visibility
   typedef struct packed {
      logic signed [`CORR_ACCUM-1:0] re;
      logic signed [`CORR_ACCUM-1:0] im;
   } vis_entry_t;

   // Whole frame, lane 0 in the low bits
   typedef vis_entry_t [`CORR_NLANE-1:0] vis_frame_t;

   // Component select, LSB of the bus address
   typedef enum logic {
      VIS_RE = 1'b0,
      VIS_IM = 1'b1
   } vis_part_e;

   // Low bus address bits: lane above part
   typedef struct packed {
      logic [1:0] lane;
      vis_part_e  part;
   } vis_addr_t;

   // Accumulator mode
   typedef enum logic {
      ACC_CLEAR = 1'b0,  // Next accepted sample starts from zero
      ACC_RUN   = 1'b1
   } acc_state_e;

endpackage

// ==== logic/vis_bank_ram.sv ====
`timescale 1ns/1ps

module vis_bank_ram (
   input  logic                 sram_ck_i,
   input  logic                 reset_i,
   input  logic                 wr_i,        // Store frame, swap banks
   input  corr_pkg::vis_frame_t frame_i,
   input  logic                 rd_en_i,
   input  logic [1:0]           rd_lane_i,
   output corr_pkg::vis_entry_t rd_entry_o   // Registered read data
);

   corr_pkg::vis_frame_t bank_q [2];  // Two complete frames
   logic                 active_q;    // Bank being filled
   logic                 rd_bank;

   // Bus side only ever sees the finished bank
   assign rd_bank = ~active_q;

   // ----------------------------------------------------------
   // Write side
   // ----------------------------------------------------------
   always_ff @(posedge sram_ck_i) begin
      if (reset_i) begin
         bank_q[0] <= '0;      // Both banks read zero out of reset
         bank_q[1] <= '0;
         active_q  <= 1'b0;
      end else if (wr_i) begin
         bank_q[active_q] <= frame_i;
         active_q         <= ~active_q;  // Frame visible next cycle
      end
   end

   // ----------------------------------------------------------
   // Read side
   // ----------------------------------------------------------
   always_ff @(posedge sram_ck_i) begin
      if (rd_en_i) begin
         rd_entry_o <= bank_q[rd_bank][rd_lane_i];
      end
   end

   // Write strobe from the accumulator must be clean
   wr_known_a : assert property (
      @(posedge sram_ck_i) disable iff (reset_i) !$isunknown(wr_i)
   ) else $error("vis_bank_ram: unknown write strobe");

   // Frame data must be fully defined when stored
   frame_known_a : assert property (
      @(posedge sram_ck_i) disable iff (reset_i) wr_i |-> !$isunknown(frame_i)
   ) else $error("vis_bank_ram: unknown frame data on write");

endmodule

// ==== logic/vis_readback.sv ====
`timescale 1ns/1ps
`include "corr_config.svh"

module vis_readback (
   input  logic                          sram_ck_i,
   input  logic                          reset_i,
   input  logic                          sram_ce_i,
   input  corr_pkg::vis_addr_t           sram_ad_i,
   output logic                          rd_en_o,     // To buffer
   output logic [1:0]                    rd_lane_o,
   input  corr_pkg::vis_entry_t          rd_entry_i,  // From buffer one cycle later
   output logic signed [`CORR_ACCUM-1:0] sram_do_o
);

   corr_pkg::vis_part_e part_q;  // Part select, aligned with rd_entry_i
   logic                vld_q;   // Read in flight in stage 2

   // ----------------------------------------------------------
   // Stage 1 passes the lane straight to the buffer
   // ----------------------------------------------------------
   assign rd_en_o   = sram_ce_i;
   assign rd_lane_o = sram_ad_i.lane;

   always_ff @(posedge sram_ck_i) begin
      if (reset_i) begin
         vld_q <= 1'b0;
      end else begin
         vld_q <= sram_ce_i;
      end
   end

   always_ff @(posedge sram_ck_i) begin
      part_q <= sram_ad_i.part;  // Payload
   end

   // ----------------------------------------------------------
   // Stage 2 muxes the component into the output register
   // ----------------------------------------------------------
   always_ff @(posedge sram_ck_i) begin
      if (reset_i) begin
         sram_do_o <= '0;
      end else if (vld_q) begin
         sram_do_o <= (part_q == corr_pkg::VIS_IM) ? rd_entry_i.im : rd_entry_i.re;
      end                        // Otherwise hold last word
   end

   // Bus address must be defined on every read
   addr_known_a : assert property (
      @(posedge sram_ck_i) disable iff (reset_i)
         sram_ce_i |-> !$isunknown(sram_ad_i)
   ) else $error("vis_readback: unknown address on read");

endmodule

// ==== verification/corr_block_tb.sv ====
`timescale 1ns/1ps
`include "corr_config.svh"

module corr_block_tb;

   localparam int pair_a [`CORR_NLANE] =
      '{`CORR_PAIR_A0, `CORR_PAIR_A1, `CORR_PAIR_A2, `CORR_PAIR_A3};
   localparam int pair_b [`CORR_NLANE] =
      '{`CORR_PAIR_B0, `CORR_PAIR_B1, `CORR_PAIR_B2, `CORR_PAIR_B3};

   logic                          sram_ck_i;
   logic                          reset_i;
   logic                          en_i;
   logic                          sw_i;
   logic                          sram_ce_i;
   corr_pkg::corr_sample_t        sample_i;
   corr_pkg::vis_addr_t           sram_ad_i;
   logic signed [`CORR_ACCUM-1:0] sram_do_o;

   integer seed;
   int     errors;
   int     checks;
   int     swap_cnt;   // Cycles until the stored frame is visible

   // ----------------------------------------------------------
   // Reference model state
   // ----------------------------------------------------------
   logic signed [`CORR_ACCUM-1:0] sum_re [`CORR_NLANE];    // Running sums
   logic signed [`CORR_ACCUM-1:0] sum_im [`CORR_NLANE];
   logic signed [`CORR_ACCUM-1:0] next_re [`CORR_NLANE];   // Stored at last switch
   logic signed [`CORR_ACCUM-1:0] next_im [`CORR_NLANE];
   logic signed [`CORR_ACCUM-1:0] shown_re [`CORR_NLANE];  // What the bus sees
   logic signed [`CORR_ACCUM-1:0] shown_im [`CORR_NLANE];

   // Two-stage mirror of the read pipeline
   logic                          ce_flag;
   logic [2:0]                    exp_addr;
   logic signed [`CORR_ACCUM-1:0] exp_word;
   logic                          s0_v, s1_v;
   logic [2:0]                    s0_a, s1_a;
   logic signed [`CORR_ACCUM-1:0] s0_x, s1_x;
   logic signed [`CORR_ACCUM-1:0] held_x;    // Word the output should keep
   logic                          wr_seen;   // Frame store observed

   corr_block corr_block_i (
      .sram_ck_i (sram_ck_i),
      .reset_i   (reset_i),
      .en_i      (en_i),
      .sw_i      (sw_i),
      .sram_ce_i (sram_ce_i),
      .sample_i  (sample_i),
      .sram_ad_i (sram_ad_i),
      .sram_do_o (sram_do_o)
   );

   always #10 sram_ck_i = ~sram_ck_i;  // 20 ns period

   function automatic int sign_value(input logic neg);
      return neg ? -1 : 1;  // Set bit is -1
   endfunction

   task automatic check_value(input logic signed [31:0] got, input logic signed [31:0] exp,
                              input string what);
      checks++;
      if (got !== exp) begin
         $display("mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
         errors++;
      end
   endtask

   // ----------------------------------------------------------
   // One clock of stimulus plus the model update
   // ----------------------------------------------------------
   task automatic drive_cycle(input logic en, input corr_pkg::corr_sample_t smp,
                              input logic sw, input logic ce, input logic [2:0] addr);
      int ar, ai, br, bi;
      @(posedge sram_ck_i);
      if (swap_cnt > 0) begin
         swap_cnt--;
         if (swap_cnt == 0) begin   // Bank swap lands at t+2
            shown_re = next_re;
            shown_im = next_im;
         end
      end
      en_i      <= en;
      sample_i  <= smp;
      sw_i      <= sw;
      sram_ce_i <= ce;
      sram_ad_i <= corr_pkg::vis_addr_t'(addr);
      ce_flag   = ce;
      exp_addr  = addr;
      exp_word  = addr[0] ? shown_im[addr[2:1]] : shown_re[addr[2:1]];  // Lane above part
      if (en) begin
         for (int l = 0; l < `CORR_NLANE; l++) begin
            ar = sign_value(smp.re[pair_a[l]]);
            ai = sign_value(smp.im[pair_a[l]]);
            br = sign_value(smp.re[pair_b[l]]);
            bi = sign_value(smp.im[pair_b[l]]);
            sum_re[l] = sum_re[l] + (ar * br + ai * bi);  // Wraps at width
            sum_im[l] = sum_im[l] + (ai * br - ar * bi);
         end
      end
      if (sw) begin               // Frame includes this cycle's sample
         next_re  = sum_re;
         next_im  = sum_im;
         swap_cnt = 2;
         wr_seen  = 1'b0;
         foreach (sum_re[l]) begin
            sum_re[l] = '0;
            sum_im[l] = '0;
         end
      end
   endtask

   task automatic idle_cycle();
      drive_cycle(1'b0, '0, 1'b0, 1'b0, 3'd0);
   endtask

   task automatic wait_frame_stored();
      int n;
      n = 0;
      while (!(swap_cnt == 0 && wr_seen)) begin
         if (n == 10) begin
            $display("timeout: no frame store seen after the bank switch");
            errors++;
            return;
         end
         idle_cycle();
         n++;
      end
   endtask

   // Let every issued read reach the checker
   task automatic drain_reads();
      int n;
      n = 0;
      idle_cycle();
      while (s0_v || s1_v) begin
         if (n == 10) begin
            $display("timeout: read results still pending after drain");
            errors++;
            return;
         end
         idle_cycle();
         n++;
      end
   endtask

   task automatic run_frame(input int len, input logic en_at_sw, input logic read_during);
      corr_pkg::corr_sample_t smp;
      logic                   en;
      for (int i = 0; i <= len; i++) begin
         smp = corr_pkg::corr_sample_t'(16'($random(seed)));
         en  = (i == len && en_at_sw) ? 1'b1 : 1'($random(seed));
         drive_cycle(en, smp, i == len, read_during & 1'($random(seed)), 3'($random(seed)));
      end
      if (read_during) begin      // Reads straddle the swap at t+1 and t+2
         repeat (3) begin
            smp = corr_pkg::corr_sample_t'(16'($random(seed)));
            drive_cycle(1'($random(seed)), smp, 1'b0, 1'b1, 3'($random(seed)));
         end
      end
      wait_frame_stored();
   endtask

   // All 8 addresses back to back in shuffled order
   task automatic read_shuffled();
      int order [8];
      int j, t;
      foreach (order[i]) order[i] = i;
      for (int i = 7; i > 0; i--) begin
         j        = $unsigned($random(seed)) % (i + 1);
         t        = order[i];
         order[i] = order[j];
         order[j] = t;
      end
      foreach (order[i]) drive_cycle(1'b0, '0, 1'b0, 1'b1, 3'(order[i]));
      drain_reads();
   endtask

   // ----------------------------------------------------------
   // Readback check two cycles after issue
   // ----------------------------------------------------------
   always @(negedge sram_ck_i) begin
      if (s1_v) begin
         check_value(sram_do_o, s1_x, $sformatf("read of address %0d", s1_a));
         held_x = s1_x;
      end else if (!reset_i) begin
         check_value(sram_do_o, held_x, "output hold with no read");  // Reset value too
      end
      if (corr_block_i.vis_wr) wr_seen = 1'b1;
      s1_v = s0_v;
      s1_a = s0_a;
      s1_x = s0_x;
      s0_v = ce_flag;
      s0_a = exp_addr;
      s0_x = exp_word;
   end

   initial begin
      int len;
      seed      = 32'h2464;
      errors    = 0;
      checks    = 0;
      swap_cnt  = 0;
      sram_ck_i = 1'b0;
      reset_i   = 1'b1;
      en_i      = 1'b0;
      sw_i      = 1'b0;
      sram_ce_i = 1'b0;
      sample_i  = '0;
      sram_ad_i = '0;
      ce_flag   = 1'b0;
      exp_addr  = '0;
      exp_word  = '0;
      s0_v      = 1'b0;
      s1_v      = 1'b0;
      held_x    = '0;
      wr_seen   = 1'b0;
      foreach (sum_re[l]) begin
         sum_re[l]   = '0;
         sum_im[l]   = '0;
         next_re[l]  = '0;
         next_im[l]  = '0;
         shown_re[l] = '0;
         shown_im[l] = '0;
      end
      repeat (8) @(posedge sram_ck_i);
      reset_i <= 1'b0;

      for (int a = 0; a < 8; a++) drive_cycle(1'b0, '0, 1'b0, 1'b1, 3'(a));  // Zero banks
      drain_reads();
      run_frame(20 + $unsigned($random(seed)) % 40, 1'b0, 1'b0);  // First frame
      read_shuffled();
      run_frame(5, 1'b1, 1'b0);   // Short frame shows the restart from zero
      read_shuffled();
      read_shuffled();            // Pure back-to-back reads
      run_frame(30, 1'b0, 1'b1);  // Reads while the next frame fills
      drain_reads();
      read_shuffled();

      // Many frames with a few long ones
      for (int f = 0; f < 24; f++) begin
         len = (f % 6 == 5) ? 300 + $unsigned($random(seed)) % 300
                            : 1 + $unsigned($random(seed)) % 60;
         run_frame(len, f[0], f % 3 == 0);
         read_shuffled();
      end

      $display("checks %0d errors %0d", checks, errors);
      if (errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule
